// ==== design/llc_evict_macros.svh ====
/*
  size parameters of the write-back path, shared by both packages and the storage RTL
  a line is 2**LLC_BLOCK_OFF_W blocks, which is also the beat count and FIFO depth
  LLC_DATA_W must be a multiple of 8 since W strobes are byte strobes
  LLC_WAY_IDX_W must be wide enough to index LLC_NUM_WAYS
*/

`ifndef LLC_EVICT_MACROS_SVH
`define LLC_EVICT_MACROS_SVH

// associativity
`define LLC_NUM_WAYS    4
`define LLC_WAY_IDX_W   2

// address split {tag, index, block offset, byte offset}
`define LLC_INDEX_W     4   // 16 sets
`define LLC_BLOCK_OFF_W 2   // 4 blocks per line
`define LLC_BYTE_OFF_W  2   // 4 bytes per block

// datapath widths
`define LLC_DATA_W      32  // one block == one W beat
`define LLC_ADDR_W      32

`endif

// ==== design/llc_cfg_pkg.sv ====
/*
  cache-side types of the eviction path
  field widths come from the shared size macros
  tag_id is only an ordering label and is never decoded by the RTL
*/

`include "llc_evict_macros.svh"

`default_nettype none

package llc_cfg_pkg;

  // address sub-fields
  typedef logic [`LLC_WAY_IDX_W-1:0]   way_idx_t;
  typedef logic [`LLC_INDEX_W-1:0]     line_idx_t;
  typedef logic [`LLC_BLOCK_OFF_W-1:0] blk_off_t;
  typedef logic [`LLC_BYTE_OFF_W-1:0]  byte_off_t;
  typedef logic [`LLC_ADDR_W-1:0]      addr_t;

  // descriptor handed along the cache pipeline
  typedef struct packed {
    addr_t      addr;     // line address, byte granular
    way_idx_t   way_ind;  // way that holds the line
    logic       evict;    // line is dirty, write it back
    logic       flush;    // descriptor belongs to a flush, dropped at the end
    logic [3:0] tag_id;   // ordering label
  } desc_t;

  // read request towards the data way
  typedef struct packed {
    way_idx_t  way_ind;
    line_idx_t line_idx;  // set index from desc addr
    blk_off_t  blk_off;
  } way_req_t;

  // read response is just the block
  typedef logic [`LLC_DATA_W-1:0] way_rsp_t;

  // line fill write, one block per cycle
  typedef struct packed {
    way_idx_t  way_ind;
    line_idx_t line_idx;
    blk_off_t  blk_off;
    way_rsp_t  data;
  } fill_t;

endpackage

`default_nettype wire

// ==== design/llc_axi_pkg.sv ====
/*
  AXI-side channel types used by the eviction path
  only W and B are modelled, AW is handled outside this block
  strb is one bit per data byte
*/

`include "llc_evict_macros.svh"

`default_nettype none

package llc_axi_pkg;

  // write data beat
  typedef struct packed {
    logic [`LLC_DATA_W-1:0]   data;
    logic [`LLC_DATA_W/8-1:0] strb;  // byte enables
    logic                     last;  // final beat of the burst
  } w_chan_t;

  // write response
  typedef struct packed {
    logic [1:0] resp;  // OKAY/EXOKAY/SLVERR/DECERR
    logic [3:0] id;
  } b_chan_t;

endpackage

`default_nettype wire

// ==== design/llc_stream_reg.sv ====
/*
  one-entry valid/ready pipeline register
  ready_o stays high while the output is being taken, so back-to-back transfers run
  at full rate; under back-pressure one item is held
  payload has no reset, only the full flag does
*/

`timescale 1ns/1ns
`default_nettype none

module llc_stream_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // upstream
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  // downstream
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  payload_t data_q;  // held item
  logic     full_q;  // stage holds an item
  logic     load;    // input transfer this cycle

  assign ready_o = ~full_q | ready_i;  // empty, or draining this cycle
  assign load    = valid_i & ready_o;
  assign data_o  = data_q;
  assign valid_o = full_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;  // refill wins over drain
    end else if (ready_i) begin
      full_q <= 1'b0;  // taken and not refilled
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/llc_beat_fifo.sv ====
/*
  fall-through FIFO for the read data of one line
  depth is 2**LLC_BLOCK_OFF_W, so a whole line fits
  a push into an empty FIFO shows up on data_o in the same cycle
  push while full and pop while empty are ignored, callers must check the flags
*/

`timescale 1ns/1ns
`include "llc_evict_macros.svh"
`default_nettype none

module llc_beat_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // write side
  input  payload_t data_i,
  input  logic     push_i,
  output logic     full_o,
  // read side
  output payload_t data_o,
  output logic     empty_o,
  input  logic     pop_i
);

  localparam int unsigned depth = 2 ** `LLC_BLOCK_OFF_W;

  typedef logic [`LLC_BLOCK_OFF_W:0] ptr_t;  // extra msb tells full from empty

  payload_t mem_q [depth];
  ptr_t     wr_ptr_q, rd_ptr_q;
  logic     mem_empty;  // nothing stored
  logic     mem_full;
  logic     bypass;     // push goes straight through
  logic     do_write;
  logic     do_read;

  assign mem_empty = (wr_ptr_q == rd_ptr_q);
  assign mem_full  = (wr_ptr_q[`LLC_BLOCK_OFF_W] != rd_ptr_q[`LLC_BLOCK_OFF_W]) &&
                     (wr_ptr_q[`LLC_BLOCK_OFF_W-1:0] == rd_ptr_q[`LLC_BLOCK_OFF_W-1:0]);

  // empty and both push and pop, so the word never gets stored
  assign bypass   = mem_empty & push_i & pop_i;
  assign do_write = push_i & ~mem_full & ~bypass;
  assign do_read  = pop_i & ~mem_empty;

  assign full_o  = mem_full;
  assign empty_o = mem_empty & ~push_i;                   // fall-through valid
  assign data_o  = mem_empty ? data_i
                             : mem_q[rd_ptr_q[`LLC_BLOCK_OFF_W-1:0]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_read) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // storage, no reset needed on data
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem_q[wr_ptr_q[`LLC_BLOCK_OFF_W-1:0]] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/llc_data_way.sv ====
/*
  data storage of all ways as one flat array {way, set, block}
  reads answer one cycle after the request and hold until taken
  a fill write always succeeds and blocks reads in its cycle
  no byte enables, a fill writes a whole block
*/

`timescale 1ns/1ns
`include "llc_evict_macros.svh"
`default_nettype none

module llc_data_way (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // read request
  input  llc_cfg_pkg::way_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // read response
  output llc_cfg_pkg::way_rsp_t rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  // line fill
  input  llc_cfg_pkg::fill_t    fill_i,
  input  logic                  fill_valid_i
);

  import llc_cfg_pkg::*;

  localparam int unsigned num_sets   = 2 ** `LLC_INDEX_W;
  localparam int unsigned num_blocks = 2 ** `LLC_BLOCK_OFF_W;
  localparam int unsigned num_words  = `LLC_NUM_WAYS * num_sets * num_blocks;

  typedef logic [`LLC_WAY_IDX_W+`LLC_INDEX_W+`LLC_BLOCK_OFF_W-1:0] word_addr_t;

  way_rsp_t   mem_q [num_words];  // SRAM model
  way_rsp_t   rsp_q;              // registered read data
  logic       rsp_valid_q;        // response pending
  logic       rd_en;
  word_addr_t rd_addr, wr_addr;

  assign rd_addr = {req_i.way_ind, req_i.line_idx, req_i.blk_off};
  assign wr_addr = {fill_i.way_ind, fill_i.line_idx, fill_i.blk_off};

  // fill has priority, reads stall behind a pending response
  assign req_ready_o = ~fill_valid_i & (~rsp_valid_q | rsp_ready_i);
  assign rd_en       = req_valid_i & req_ready_o;

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (rd_en) begin
      rsp_valid_q <= 1'b1;  // new word replaces the taken one
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      mem_q[wr_addr] <= fill_i.data;
    end
    if (rd_en) begin
      rsp_q <= mem_q[rd_addr];  // never in the same cycle as a fill
    end
  end

endmodule

`default_nettype wire

// ==== design/llc_evict_unit.sv ====
/*
  eviction unit, holds one descriptor at a time
  state is {busy_q, send_q}: 00 idle, 01 send, 10 evict, 11 wait for B
  an evict always writes back the full line, blocks 0 up to the last, one beat each
  flush descriptors are dropped with a one-cycle flush_done_o pulse
  the B response code is accepted but not checked
*/

`timescale 1ns/1ns
`default_nettype none

module llc_evict_unit (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // descriptor in
  input  llc_cfg_pkg::desc_t    desc_i,
  input  logic                  desc_valid_i,
  output logic                  desc_ready_o,
  // descriptor out
  output llc_cfg_pkg::desc_t    desc_o,
  output logic                  desc_valid_o,
  input  logic                  desc_ready_i,
  // data way read
  output llc_cfg_pkg::way_req_t way_req_o,
  output logic                  way_req_valid_o,
  input  logic                  way_req_ready_i,
  input  llc_cfg_pkg::way_rsp_t way_rsp_i,
  input  logic                  way_rsp_valid_i,
  output logic                  way_rsp_ready_o,
  // AXI W and B
  output llc_axi_pkg::w_chan_t  w_o,
  output logic                  w_valid_o,
  input  logic                  w_ready_i,
  input  llc_axi_pkg::b_chan_t  b_i,
  input  logic                  b_valid_i,
  output logic                  b_ready_o,
  output logic                  flush_done_o
);

  import llc_cfg_pkg::*;

  // set index sits above byte and block offset
  localparam int unsigned idx_lsb = $bits(byte_off_t) + $bits(blk_off_t);

  desc_t    desc_q;
  logic     busy_q, busy_d;     // evicting or waiting for B
  logic     send_q, send_d;     // descriptor ready to leave, or B pending
  logic     load_desc;
  logic     try_load;           // unit can take a new descriptor this cycle
  logic     load_cnt;           // start of an eviction
  blk_off_t blk_off_q;          // next block to request
  logic     req_done_q;         // all requests issued
  logic     en_cnt_req;
  blk_off_t beats_left_q;       // 0 means the current beat is last
  logic     en_cnt_w;
  logic     fifo_full, fifo_empty, fifo_push, fifo_pop;
  way_rsp_t fifo_data;

  // read data path into the FIFO and out on W
  assign fifo_push       = way_rsp_valid_i & ~fifo_full;
  assign way_rsp_ready_o = ~fifo_full;
  assign fifo_pop        = w_ready_i & ~fifo_empty;
  assign w_valid_o       = ~fifo_empty;

  assign w_o.data = fifo_data;
  assign w_o.strb = '1;                       // full line, all bytes
  assign w_o.last = (beats_left_q == '0);

  assign way_req_o.way_ind  = desc_q.way_ind;
  assign way_req_o.line_idx = desc_q.addr[idx_lsb +: $bits(line_idx_t)];
  assign way_req_o.blk_off  = blk_off_q;

  assign desc_o = desc_q;

  always_comb begin
    busy_d          = busy_q;
    send_d          = send_q;
    load_desc       = 1'b0;
    load_cnt        = 1'b0;
    try_load        = 1'b0;
    en_cnt_req      = 1'b0;
    en_cnt_w        = 1'b0;
    desc_ready_o    = 1'b0;
    desc_valid_o    = 1'b0;
    way_req_valid_o = 1'b0;
    b_ready_o       = 1'b0;
    flush_done_o    = 1'b0;

    unique case ({busy_q, send_q})
      2'b00: try_load = 1'b1;  // idle
      2'b01: begin             // send along, or drop a flush
        if (desc_q.flush) begin
          flush_done_o = 1'b1;
          send_d       = 1'b0;
          try_load     = 1'b1;
        end else begin
          desc_valid_o = 1'b1;
          if (desc_ready_i) begin
            send_d   = 1'b0;
            try_load = 1'b1;   // refill in the same cycle
          end
        end
      end
      2'b10: begin             // evict
        if (!req_done_q) begin
          way_req_valid_o = 1'b1;
          en_cnt_req      = way_req_ready_i;
        end
        if (fifo_pop) begin
          en_cnt_w = 1'b1;
          if (w_o.last) begin
            b_ready_o = 1'b1;  // B may arrive with the last beat
            send_d    = 1'b1;
            if (b_valid_i) begin
              busy_d = 1'b0;
            end
          end
        end
      end
      2'b11: begin             // wait for B
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          busy_d = 1'b0;
        end
      end
      default: ;
    endcase

    if (try_load) begin
      desc_ready_o = 1'b1;
      if (desc_valid_i) begin
        load_desc = 1'b1;
        if (desc_i.evict) begin
          busy_d   = 1'b1;
          send_d   = 1'b0;
          load_cnt = 1'b1;
        end else begin
          send_d = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q       <= 1'b0;
      send_q       <= 1'b0;
      blk_off_q    <= '0;
      req_done_q   <= 1'b0;
      beats_left_q <= '0;
    end else begin
      busy_q <= busy_d;
      send_q <= send_d;
      if (load_cnt) begin
        blk_off_q    <= '0;
        req_done_q   <= 1'b0;
        beats_left_q <= '1;                   // one beat per block
      end else begin
        if (en_cnt_req) begin
          blk_off_q <= blk_off_q + 1'b1;
          if (blk_off_q == '1) begin
            req_done_q <= 1'b1;               // counter wrapped
          end
        end
        if (en_cnt_w) begin
          beats_left_q <= beats_left_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_desc) begin
      desc_q <= desc_i;
    end
  end

  llc_beat_fifo #(
    .payload_t ( way_rsp_t )
  ) u_beat_fifo (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .data_i  ( way_rsp_i  ),
    .push_i  ( fifo_push  ),
    .full_o  ( fifo_full  ),
    .data_o  ( fifo_data  ),
    .empty_o ( fifo_empty ),
    .pop_i   ( fifo_pop   )
  );

endmodule

`default_nettype wire

// ==== design/llc_evict_top.sv ====
/*
  write-back path: input stage, eviction unit, output stage, data way alongside
  AW is not generated here, the surrounding logic must issue it per eviction
  latency varies, watch desc_valid_o, w last and flush_done_o
*/

`timescale 1ns/1ns
`default_nettype none

module llc_evict_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // descriptors from the cache
  input  llc_cfg_pkg::desc_t   desc_i,
  input  logic                 desc_valid_i,
  output logic                 desc_ready_o,
  // descriptors to the next unit
  output llc_cfg_pkg::desc_t   desc_o,
  output logic                 desc_valid_o,
  input  logic                 desc_ready_i,
  // AXI W and B
  output llc_axi_pkg::w_chan_t w_o,
  output logic                 w_valid_o,
  input  logic                 w_ready_i,
  input  llc_axi_pkg::b_chan_t b_i,
  input  logic                 b_valid_i,
  output logic                 b_ready_o,
  // line fill
  input  llc_cfg_pkg::fill_t   fill_i,
  input  logic                 fill_valid_i,
  output logic                 flush_done_o
);

  import llc_cfg_pkg::*;

  desc_t    in_desc, ev_desc;                     // stage to unit, unit to stage
  logic     in_valid, in_ready, ev_valid, ev_ready;
  way_req_t way_req;
  logic     way_req_valid, way_req_ready;
  way_rsp_t way_rsp;
  logic     way_rsp_valid, way_rsp_ready;

  llc_stream_reg #(.payload_t(desc_t)) u_in_stage (
    .clk_i   ( clk_i        ), .rst_i   ( rst_i        ),
    .data_i  ( desc_i       ), .valid_i ( desc_valid_i ), .ready_o ( desc_ready_o ),
    .data_o  ( in_desc      ), .valid_o ( in_valid     ), .ready_i ( in_ready     )
  );

  llc_evict_unit u_evict (
    .clk_i           ( clk_i         ), .rst_i           ( rst_i         ),
    .desc_i          ( in_desc       ), .desc_valid_i    ( in_valid      ),
    .desc_ready_o    ( in_ready      ),
    .desc_o          ( ev_desc       ), .desc_valid_o    ( ev_valid      ),
    .desc_ready_i    ( ev_ready      ),
    .way_req_o       ( way_req       ), .way_req_valid_o ( way_req_valid ),
    .way_req_ready_i ( way_req_ready ),
    .way_rsp_i       ( way_rsp       ), .way_rsp_valid_i ( way_rsp_valid ),
    .way_rsp_ready_o ( way_rsp_ready ),
    .w_o             ( w_o           ), .w_valid_o       ( w_valid_o     ),
    .w_ready_i       ( w_ready_i     ),
    .b_i             ( b_i           ), .b_valid_i       ( b_valid_i     ),
    .b_ready_o       ( b_ready_o     ),
    .flush_done_o    ( flush_done_o  )
  );

  llc_stream_reg #(.payload_t(desc_t)) u_out_stage (
    .clk_i   ( clk_i   ), .rst_i   ( rst_i        ),
    .data_i  ( ev_desc ), .valid_i ( ev_valid     ), .ready_o ( ev_ready     ),
    .data_o  ( desc_o  ), .valid_o ( desc_valid_o ), .ready_i ( desc_ready_i )
  );

  llc_data_way u_way (
    .clk_i        ( clk_i         ), .rst_i        ( rst_i         ),
    .req_i        ( way_req       ), .req_valid_i  ( way_req_valid ),
    .req_ready_o  ( way_req_ready ),
    .rsp_o        ( way_rsp       ), .rsp_valid_o  ( way_rsp_valid ),
    .rsp_ready_i  ( way_rsp_ready ),
    .fill_i       ( fill_i        ), .fill_valid_i ( fill_valid_i  )
  );

endmodule

`default_nettype wire

// ==== testbench/llc_evict_assertions.sv ====
/*
  protocol checks for the eviction unit, bound into every llc_evict_unit
  all checks are off while rst_i is high
  fail_cnt counts failed checks over the whole run
*/

`timescale 1ns/1ns
`default_nettype none

module llc_evict_assertions (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 busy_i,        // unit in evict or B wait
  input logic                 fifo_empty_i,
  input logic                 w_valid_i,
  input logic                 w_ready_i,
  input llc_axi_pkg::w_chan_t w_i,
  input logic                 b_ready_i
);

  int unsigned fail_cnt = 0;

  // idle and send never hold read data
  fifo_empty_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    !busy_i |-> fifo_empty_i)
    else begin
      $error("beat FIFO holds data while the unit is not busy");
      fail_cnt++;
    end

  // a stalled beat keeps valid and payload
  w_stable_until_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    (w_valid_i && !w_ready_i) |=> (w_valid_i && $stable(w_i)))
    else begin
      $error("W beat changed or dropped before it was taken");
      fail_cnt++;
    end

  // B is only accepted in evict or B wait, once the last beat goes or has gone
  no_b_ready_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    b_ready_i |-> (busy_i && (!w_valid_i || (w_ready_i && w_i.last))))
    else begin
      $error("b_ready_o high in idle or send state, or before the last W beat");
      fail_cnt++;
    end

endmodule

bind llc_evict_unit llc_evict_assertions u_evict_assert (
  .clk_i        ( clk_i      ),
  .rst_i        ( rst_i      ),
  .busy_i       ( busy_q     ),
  .fifo_empty_i ( fifo_empty ),
  .w_valid_i    ( w_valid_o  ),
  .w_ready_i    ( w_ready_i  ),
  .w_i          ( w_o        ),
  .b_ready_i    ( b_ready_o  )
);

`default_nettype wire

// ==== testbench/llc_evict_tb.sv ====
/*
  directed testbench of the write-back path
  the testbench plays the cache (fill port), the AXI slave (W ready, B) and the next unit
  one eviction or flush is in flight at a time, AW is not modelled
  outputs are sampled at the rising edge, inputs change on the falling edge
*/

`timescale 1ns/1ns
`include "llc_evict_macros.svh"
`default_nettype none

module llc_evict_tb;

  import llc_cfg_pkg::*;
  import llc_axi_pkg::*;

  localparam int unsigned timeout_cycles = 200;
  localparam int unsigned num_beats      = 2 ** `LLC_BLOCK_OFF_W;  // one beat per block
  localparam int unsigned idx_lsb        = `LLC_BYTE_OFF_W + `LLC_BLOCK_OFF_W;

  logic    clk_i;
  logic    rst_i;
  desc_t   desc_i;
  logic    desc_valid_i;
  logic    desc_ready_o;
  desc_t   desc_o;
  logic    desc_valid_o;
  logic    desc_ready_i;
  w_chan_t w_o;
  logic    w_valid_o;
  logic    w_ready_i;
  b_chan_t b_i;
  logic    b_valid_i;
  logic    b_ready_o;
  fill_t   fill_i;
  logic    fill_valid_i;
  logic    flush_done_o;

  // what the monitor saw
  desc_t           desc_out_q[$];
  longint unsigned desc_out_cyc[$];   // cycle of each desc_o transfer
  w_chan_t         w_beat_q[$];
  longint unsigned cycle_cnt;
  longint unsigned b_cyc;             // last B transfer
  longint unsigned flush_cyc;         // last flush_done_o pulse
  int unsigned     flush_cnt;

  way_rsp_t    fill_words[num_beats];  // last line written through fill_i
  logic        w_rand_en;              // random W back-pressure
  int unsigned err_cnt;
  int unsigned test_cnt;
  int unsigned test_fail_cnt;
  int unsigned asrt_cnt;

  llc_evict_top u_llc_evict_top (
    .clk_i        ( clk_i        ), .rst_i        ( rst_i        ),
    .desc_i       ( desc_i       ), .desc_valid_i ( desc_valid_i ),
    .desc_ready_o ( desc_ready_o ),
    .desc_o       ( desc_o       ), .desc_valid_o ( desc_valid_o ),
    .desc_ready_i ( desc_ready_i ),
    .w_o          ( w_o          ), .w_valid_o    ( w_valid_o    ),
    .w_ready_i    ( w_ready_i    ),
    .b_i          ( b_i          ), .b_valid_i    ( b_valid_i    ),
    .b_ready_o    ( b_ready_o    ),
    .fill_i       ( fill_i       ), .fill_valid_i ( fill_valid_i ),
    .flush_done_o ( flush_done_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  // transfers happen where valid and ready meet at the rising edge
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (!rst_i) begin
      if (desc_valid_o && desc_ready_i) begin
        desc_out_q.push_back(desc_o);
        desc_out_cyc.push_back(cycle_cnt);
      end
      if (w_valid_o && w_ready_i) w_beat_q.push_back(w_o);
      if (b_valid_i && b_ready_o) b_cyc = cycle_cnt;
      if (flush_done_o) begin
        flush_cnt++;             // one per high cycle
        flush_cyc = cycle_cnt;
      end
    end
  end

  always @(negedge clk_i) begin
    w_ready_i = w_rand_en ? (($urandom % 2) != 0) : 1'b1;
  end

  task automatic compare_desc(input string name, input desc_t got, input desc_t exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_w(input string name, input w_chan_t got, input w_chan_t exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s got=%b exp=%b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR t=%0t %s", $time, what);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int unsigned err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("test %s: ok", name);
    end else begin
      test_fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  function automatic desc_t make_desc(input line_idx_t idx, input way_idx_t way,
                                      input logic evict, input logic flush,
                                      input logic [3:0] tag);
    desc_t d;
    d.addr                          = $urandom;  // random tag bits
    d.addr[idx_lsb +: `LLC_INDEX_W] = idx;
    d.addr[idx_lsb-1:0]             = '0;        // line aligned
    d.way_ind                       = way;
    d.evict                         = evict;
    d.flush                         = flush;
    d.tag_id                        = tag;
    return d;
  endfunction

  // leaves desc_valid_i high after the transfer, end_desc drops it
  task automatic send_desc(input desc_t d);
    int unsigned t;
    t = 0;
    @(negedge clk_i);
    desc_i       = d;
    desc_valid_i = 1'b1;
    @(posedge clk_i);
    while (!desc_ready_o) begin
      t++;
      if (t == timeout_cycles) begin
        report_error("timeout, descriptor input never ready");
        return;
      end
      @(posedge clk_i);
    end
  endtask

  task automatic end_desc();
    @(negedge clk_i);
    desc_valid_i = 1'b0;
  endtask

  task automatic clear_monitor();
    desc_out_q.delete();
    desc_out_cyc.delete();
    w_beat_q.delete();
  endtask

  task automatic wait_desc_out(input int unsigned n, output bit ok);
    int unsigned t;
    t  = 0;
    ok = 1'b1;
    do begin
      @(negedge clk_i);
      t++;
      if (t == timeout_cycles) begin
        report_error("timeout waiting for descriptors on desc_o");
        ok = 1'b0;
        return;
      end
    end while (desc_out_q.size() < n);
  endtask

  task automatic wait_beats(input int unsigned n, output bit ok);
    int unsigned t;
    t  = 0;
    ok = 1'b1;
    do begin
      @(negedge clk_i);
      t++;
      if (t == timeout_cycles) begin
        report_error("timeout waiting for W beats");
        ok = 1'b0;
        return;
      end
    end while (w_beat_q.size() < n);
  endtask

  task automatic wait_flush(input int unsigned n, output bit ok);
    int unsigned t;
    t  = 0;
    ok = 1'b1;
    do begin
      @(negedge clk_i);
      t++;
      if (t == timeout_cycles) begin
        report_error("timeout waiting for flush_done_o");
        ok = 1'b0;
        return;
      end
    end while (flush_cnt < n);
  endtask

  // new random words for all blocks of one line
  task automatic fill_line(input way_idx_t way, input line_idx_t idx);
    for (int k = 0; k < num_beats; k++) begin
      @(negedge clk_i);
      fill_words[k]    = $urandom;
      fill_i.way_ind   = way;
      fill_i.line_idx  = idx;
      fill_i.blk_off   = blk_off_t'(k);
      fill_i.data      = fill_words[k];
      fill_valid_i     = 1'b1;
    end
    @(negedge clk_i);
    fill_valid_i = 1'b0;
  endtask

  // fill, evict, answer B, then check beats and the fate of the descriptor
  task automatic run_eviction(input logic rand_mode, input logic flush,
                              input way_idx_t way, input line_idx_t idx,
                              input logic [3:0] tag);
    desc_t       d;
    w_chan_t     exp;
    int unsigned b_delay;
    int unsigned base;
    int unsigned t;
    bit          ok;
    fill_line(way, idx);
    b_delay = rand_mode ? ($urandom % 8) + 1 : 1;
    d       = make_desc(idx, way, 1'b1, flush, tag);
    clear_monitor();
    base = flush_cnt;
    send_desc(d);
    w_rand_en = rand_mode;
    end_desc();
    wait_beats(num_beats, ok);
    if (!ok) begin
      w_rand_en = 1'b0;
      return;
    end
    repeat (b_delay) @(negedge clk_i);  // slave holds B back
    if (desc_out_q.size() != 0 || flush_cnt != base)
      report_error("descriptor left or flush done before the B response");
    b_i.resp  = 2'b00;
    b_i.id    = tag;
    b_valid_i = 1'b1;
    t = 0;
    @(posedge clk_i);
    while (!b_ready_o) begin
      t++;
      if (t == timeout_cycles) begin
        report_error("timeout, b_ready_o never rose");
        break;
      end
      @(posedge clk_i);
    end
    w_rand_en = 1'b0;
    @(negedge clk_i);
    b_valid_i = 1'b0;
    if (flush) wait_flush(base + 1, ok);
    else wait_desc_out(1, ok);
    repeat (4) @(negedge clk_i);  // room for anything extra to show up
    if (w_beat_q.size() != num_beats)
      report_error($sformatf("%0d W beats instead of %0d", w_beat_q.size(), num_beats));
    for (int k = 0; k < num_beats && k < w_beat_q.size(); k++) begin
      exp.data = fill_words[k];
      exp.strb = '1;
      exp.last = (k == num_beats - 1);
      compare_w($sformatf("w_o beat %0d", k), w_beat_q[k], exp);
    end
    if (flush) begin
      if (flush_cnt != base + 1) report_error("flush_done_o not pulsed exactly once");
      if (flush_cyc <= b_cyc) report_error("flush_done_o before the B transfer");
      if (desc_out_q.size() != 0) report_error("flush descriptor passed on to desc_o");
    end else if (desc_out_q.size() != 1) begin
      report_error("evicted descriptor not passed on exactly once");
    end else begin
      compare_desc("desc_o", desc_out_q[0], d);
      if (desc_out_cyc[0] <= b_cyc) report_error("descriptor left before the B transfer");
    end
  endtask

  task automatic test_reset();
    int unsigned e;
    e = err_cnt;
    @(negedge clk_i);
    compare_bit("desc_valid_o", desc_valid_o, 1'b0);
    compare_bit("w_valid_o", w_valid_o, 1'b0);
    compare_bit("b_ready_o", b_ready_o, 1'b0);
    compare_bit("flush_done_o", flush_done_o, 1'b0);
    compare_bit("desc_ready_o", desc_ready_o, 1'b1);
    finish_test("reset", e);
  endtask

  task automatic test_passthrough();
    desc_t       exp_q[$];
    desc_t       d;
    int unsigned e;
    bit          ok;
    e = err_cnt;
    clear_monitor();
    for (int k = 0; k < 5; k++) begin
      d = make_desc(line_idx_t'(k * 3), way_idx_t'(k), 1'b0, 1'b0, 4'(k + 1));
      exp_q.push_back(d);
      send_desc(d);   // back to back, valid stays high
    end
    end_desc();
    wait_desc_out(exp_q.size(), ok);
    repeat (4) @(negedge clk_i);
    if (desc_out_q.size() != exp_q.size()) report_error("wrong number of descriptors out");
    for (int k = 0; k < exp_q.size() && k < desc_out_q.size(); k++)
      compare_desc($sformatf("desc_o %0d", k), desc_out_q[k], exp_q[k]);
    if (w_beat_q.size() != 0) report_error("W beat on a non-evict descriptor");
    finish_test("passthrough", e);
  endtask

  task automatic test_evict();
    int unsigned e;
    e = err_cnt;
    run_eviction(1'b0, 1'b0, 2'd1, 4'd5, 4'ha);
    finish_test("evict", e);
  endtask

  task automatic test_evict_stall();
    int unsigned e;
    e = err_cnt;
    run_eviction(1'b1, 1'b0, 2'd1, 4'd5, 4'hb);
    finish_test("evict with W and B stalls", e);
  endtask

  task automatic test_flush();
    int unsigned e;
    int unsigned base;
    bit          ok;
    e = err_cnt;
    clear_monitor();
    base = flush_cnt;
    send_desc(make_desc(4'd2, 2'd0, 1'b0, 1'b1, 4'hc));
    end_desc();
    wait_flush(base + 1, ok);
    repeat (4) @(negedge clk_i);
    if (flush_cnt != base + 1) report_error("flush_done_o not pulsed exactly once");
    if (desc_out_q.size() != 0) report_error("flush descriptor passed on to desc_o");
    if (w_beat_q.size() != 0) report_error("W beat on a flush without evict");
    run_eviction(1'b0, 1'b1, 2'd2, 4'd12, 4'hd);  // dirty line in a flush
    finish_test("flush", e);
  endtask

  task automatic test_backpressure();
    desc_t       exp_q[$];
    desc_t       d;
    int unsigned e;
    bit          ok;
    e = err_cnt;
    clear_monitor();
    @(negedge clk_i);
    desc_ready_i = 1'b0;
    // three stages deep, input, unit and output
    for (int k = 0; k < 3; k++) begin
      d = make_desc(line_idx_t'(k + 7), way_idx_t'(k), 1'b0, 1'b0, 4'(k + 4));
      exp_q.push_back(d);
      send_desc(d);
    end
    end_desc();
    repeat (5) @(negedge clk_i);
    // oldest one waits at the output, every stage full so the input is blocked
    compare_bit("desc_valid_o", desc_valid_o, 1'b1);
    compare_desc("desc_o held", desc_o, exp_q[0]);
    compare_bit("desc_ready_o", desc_ready_o, 1'b0);
    desc_ready_i = 1'b1;
    wait_desc_out(exp_q.size(), ok);
    repeat (4) @(negedge clk_i);
    if (desc_out_q.size() != exp_q.size()) report_error("descriptors lost or duplicated");
    for (int k = 0; k < exp_q.size() && k < desc_out_q.size(); k++)
      compare_desc($sformatf("desc_o %0d", k), desc_out_q[k], exp_q[k]);
    finish_test("output back-pressure", e);
  endtask

  initial begin
    void'($urandom(32'hfa83));
    cycle_cnt     = 0;
    b_cyc         = 0;
    flush_cyc     = 0;
    flush_cnt     = 0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    w_rand_en     = 1'b0;
    desc_i        = '0;
    desc_valid_i  = 1'b0;
    desc_ready_i  = 1'b1;
    w_ready_i     = 1'b1;
    b_i           = '0;
    b_valid_i     = 1'b0;
    fill_i        = '0;
    fill_valid_i  = 1'b0;
    rst_i         = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_reset();
    test_passthrough();
    test_evict();
    test_evict_stall();
    test_flush();
    test_backpressure();

    asrt_cnt = u_llc_evict_top.u_evict.u_evict_assert.fail_cnt;
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             test_cnt, test_fail_cnt, err_cnt, asrt_cnt);
    if (err_cnt == 0 && asrt_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== llc_evict.f ====
+incdir+design
design/llc_cfg_pkg.sv
design/llc_axi_pkg.sv
design/llc_stream_reg.sv
design/llc_beat_fifo.sv
design/llc_data_way.sv
design/llc_evict_unit.sv
design/llc_evict_top.sv
testbench/llc_evict_assertions.sv
testbench/llc_evict_tb.sv
